// ==== lsu_top.f ====
hw/lsu_pkg.sv
hw/lsu_issue.sv
hw/lsu_load_port.sv
hw/lsu_store_port.sv
hw/lsu_writeback.sv
hw/lsu_top.sv
verif/lsu_asserts.sv
verif/lsu_tb.sv

// ==== Makefile ====
# Verilator flow for the memory stage

VERILATOR ?= verilator
TOP       ?= lsu_tb
FILELIST  ?= lsu_top.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)

sim: $(BUILD)/V$(TOP)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -qx "TEST OK" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== verif/lsu_tb.sv ====
`default_nettype none

module lsu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int nreq = 400;
    localparam int tmo = 300;                   // cycles per wait
    localparam logic [3:0] dut_axi_id = 4'h6;

    typedef struct packed {
        logic [1:0]  kind;                      // 0 pass, 1 load, 2 store
        logic [2:0]  funct3;
        logic [31:0] addr;
        logic [31:0] sdata;
        logic [4:0]  rd;
        logic        reg_wen;
        logic [31:0] pc;
    } req_t;

    logic clock = 0, reset = 1;
    logic in_valid, in_mem_ren, in_mem_wen, in_reg_wen, wb_ready;
    logic [31:0] in_pc, in_addr, in_store_data;
    logic [4:0] in_rd;
    logic [2:0] in_funct3;
    wire in_ready, wb_valid, wb_reg_wen, wb_err;
    wire [31:0] wb_data, wb_pc;
    wire [4:0] wb_rd;
    logic arready, rvalid, rlast, awready, wready, bvalid;
    logic [31:0] rdata;
    logic [1:0] rresp, bresp;
    logic [3:0] rid, bid;
    wire arvalid, rready, awvalid, wvalid, wlast, bready;
    wire [31:0] araddr, awaddr, wdata;
    wire [3:0] arid, awid, wstrb;
    wire [7:0] arlen, awlen;
    wire [2:0] arsize, awsize;
    wire [1:0] arburst, awburst;

    integer seed = 36423;
    int errors = 0, timeouts = 0, checked = 0;
    logic [31:0] mem [256];                     // AXI slave memory
    logic [31:0] mirror [256];                  // reference copy
    req_t exp_q[$];
    logic err_q[$];
    req_t cur;
    logic ar_have, r_fire, aw_have, w_have, b_fire, b_ok;
    logic [31:0] w_data;
    logic [3:0] w_strb;

    lsu_top #(.axi_id(dut_axi_id)) u_lsu_top (.*);

    always #50 clock = !clock;

    function automatic int rnd(input int n);
        rnd = $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [31:0] fill(input logic [7:0] i);
        fill = {i, ~i, i ^ 8'h5a, {i[3:0], i[7:4]} ^ 8'hc3};
    endfunction

    function automatic logic [2:0] size_of(input logic [2:0] f3);
        size_of = (f3[1:0] == 2'b00) ? 3'd0 : (f3[1:0] == 2'b01) ? 3'd1 : 3'd2;
    endfunction

    function automatic logic [3:0] strb_of(input req_t r);
        case (r.funct3)
            3'b000:  strb_of = 4'b0001 << r.addr[1:0];
            3'b001:  strb_of = 4'b0011 << r.addr[1:0];
            default: strb_of = 4'b1111;
        endcase
    endfunction

    // expected load result from the mirror word
    function automatic logic [31:0] load_value(input req_t r);
        logic [31:0] lane;
        lane = mirror[r.addr[9:2]] >> (8 * r.addr[1:0]);
        case (r.funct3)
            3'b000:  load_value = {{24{lane[7]}}, lane[7:0]};
            3'b001:  load_value = {{16{lane[15]}}, lane[15:0]};
            3'b100:  load_value = {24'h0, lane[7:0]};
            3'b101:  load_value = {16'h0, lane[15:0]};
            default: load_value = lane;
        endcase
    endfunction

    // AXI slave, read side then write side
    always @(negedge clock) begin
        logic b_start;
        if (!reset) begin
            if (r_fire) begin
                rvalid = 0;
                r_fire = 0;
                ar_have = 0;
            end
            if (!ar_have) begin
                arready = rnd(3) == 0;
                if (arvalid && arready) begin
                    assert (araddr == cur.addr) else begin
                        $display("ERR araddr got %h exp %h", araddr, cur.addr);
                        errors++;
                    end
                    assert (arsize == size_of(cur.funct3) && arlen == 0) else begin
                        $display("ERR arsize got %h exp %h arlen got %h exp 00",
                                 arsize, size_of(cur.funct3), arlen);
                        errors++;
                    end
                    assert (arid == dut_axi_id && arburst == 2'b01) else begin
                        $display("ERR arid got %h exp %h arburst got %h exp 1",
                                 arid, dut_axi_id, arburst);
                        errors++;
                    end
                    rid = arid;                 // slave echoes the id
                    ar_have = 1;
                end
            end else begin
                arready = 0;
                if (!rvalid && rnd(3) == 0) begin
                    rvalid = 1;
                    rdata = mem[cur.addr[9:2]];
                    rresp = (rnd(16) == 0) ? 2'b10 : 2'b00;
                    err_q.push_back(rresp != 2'b00);
                end
            end
            if (rvalid && rready) r_fire = 1;

            if (b_fire) begin
                bvalid = 0;
                b_fire = 0;
                aw_have = 0;
                w_have = 0;
            end
            b_start = aw_have && w_have && !bvalid;    // both handshakes already done
            if (!aw_have) begin
                awready = rnd(2) == 0;
                if (awvalid && awready) begin
                    assert (awaddr == cur.addr && awlen == 0
                            && awsize == size_of(cur.funct3)) else begin
                        $display("ERR awaddr got %h exp %h awsize got %h exp %h awlen got %h",
                                 awaddr, cur.addr, awsize, size_of(cur.funct3), awlen);
                        errors++;
                    end
                    assert (awid == dut_axi_id && awburst == 2'b01) else begin
                        $display("ERR awid got %h exp %h awburst got %h exp 1",
                                 awid, dut_axi_id, awburst);
                        errors++;
                    end
                    bid = awid;
                    aw_have = 1;
                end
            end else awready = 0;
            if (!w_have) begin
                wready = rnd(2) == 0;
                if (wvalid && wready) begin
                    assert (wdata == cur.sdata << (8 * cur.addr[1:0])) else begin
                        $display("ERR wdata got %h exp %h", wdata,
                                 cur.sdata << (8 * cur.addr[1:0]));
                        errors++;
                    end
                    assert (wstrb == strb_of(cur) && wlast) else begin
                        $display("ERR wstrb got %h exp %h wlast %h", wstrb, strb_of(cur), wlast);
                        errors++;
                    end
                    w_data = wdata;
                    w_strb = wstrb;
                    w_have = 1;
                end
            end else wready = 0;
            if (b_start && rnd(3) == 0) begin
                bvalid = 1;
                b_ok = rnd(16) != 0;
                bresp = b_ok ? 2'b00 : 2'b10;
                err_q.push_back(!b_ok);
                for (int i = 0; i < 4; i++)
                    if (b_ok && w_strb[i]) mem[cur.addr[9:2]][8*i +: 8] = w_data[8*i +: 8];
            end
            if (bvalid && bready) b_fire = 1;
        end
    end

    // writeback sink with random back-pressure
    always @(negedge clock) begin
        req_t r;
        logic [31:0] exp_data;
        logic exp_err;
        logic [3:0] exp_strb;
        logic [31:0] exp_word;
        if (!reset) begin
            wb_ready = rnd(4) != 0;
            if (wb_valid && wb_ready) begin
                if (exp_q.size() == 0) begin
                    $display("writeback seen with no request outstanding");
                    errors++;
                end else begin
                    r = exp_q.pop_front();
                    exp_err = 0;
                    if (r.kind != 0) begin
                        if (err_q.size() == 0) begin
                            $display("no AXI response recorded for a memory request");
                            errors++;
                        end else exp_err = err_q.pop_front();
                    end
                    exp_data = (r.kind == 0) ? r.addr : (r.kind == 1) ? load_value(r) : 32'h0;
                    if (r.kind == 2 && !exp_err) begin
                        exp_strb = strb_of(r);
                        exp_word = r.sdata << (8 * r.addr[1:0]);
                        for (int i = 0; i < 4; i++)
                            if (exp_strb[i])
                                mirror[r.addr[9:2]][8*i +: 8] = exp_word[8*i +: 8];
                    end
                    assert (wb_data == exp_data) else begin
                        $display("ERR wb_data got %h exp %h", wb_data, exp_data);
                        errors++;
                    end
                    assert (wb_rd == r.rd && wb_reg_wen == r.reg_wen && wb_pc == r.pc) else begin
                        $display("ERR wb_pc got %h exp %h wb_rd got %h exp %h", wb_pc, r.pc,
                                 wb_rd, r.rd);
                        $display("ERR wb_reg_wen got %h exp %h", wb_reg_wen, r.reg_wen);
                        errors++;
                    end
                    assert (wb_err == exp_err) else begin
                        $display("ERR wb_err got %h exp %h", wb_err, exp_err);
                        errors++;
                    end
                    checked++;
                end
            end
        end
    end

    initial begin
        logic stop;
        int t;
        req_t r;
        logic [2:0] f3s [5];
        stop = 0;
        f3s = '{3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
        {in_valid, in_mem_ren, in_mem_wen, in_reg_wen, wb_ready} = '0;
        {in_pc, in_addr, in_store_data, in_rd, in_funct3} = '0;
        {arready, rvalid, awready, wready, bvalid} = '0;
        rdata = 0;
        rresp = 0;
        bresp = 0;
        rlast = 1;
        rid = 0;
        bid = 0;
        {ar_have, r_fire, aw_have, w_have, b_fire} = '0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = fill(8'(i));
            mirror[i] = fill(8'(i));
        end
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 0;
        assert (in_ready && !wb_valid && !arvalid && !rready && !awvalid && !wvalid
                && !bready) else begin
            $display("handshake outputs not idle after reset");
            errors++;
        end

        for (int n = 0; n < nreq && !stop; n++) begin
            t = 0;
            while (!in_ready && t < tmo) begin
                @(negedge clock);
                t++;
            end
            if (!in_ready) begin
                $display("timeout waiting for in_ready");
                timeouts++;
                stop = 1;
            end else begin
                r.kind = 2'(rnd(3));
                r.funct3 = (r.kind == 2) ? 3'(rnd(3)) : f3s[rnd(5)];
                r.addr = {22'h0, 8'(rnd(256)), 2'b00};
                if (r.kind == 0) r.addr = $random(seed);
                else if (size_of(r.funct3) == 0) r.addr[1:0] = 2'(rnd(4));
                else if (size_of(r.funct3) == 1) r.addr[1] = 1'(rnd(2));
                r.sdata = $random(seed);
                r.rd = 5'(rnd(32));
                r.reg_wen = 1'(rnd(2));
                r.pc = $random(seed);
                cur = r;
                exp_q.push_back(r);
                in_valid = 1;
                in_mem_ren = r.kind == 1;
                in_mem_wen = r.kind == 2;
                {in_funct3, in_addr, in_store_data} = {r.funct3, r.addr, r.sdata};
                {in_rd, in_reg_wen, in_pc} = {r.rd, r.reg_wen, r.pc};
                @(negedge clock);
                in_valid = 0;
                if (r.kind == 0)
                    assert (wb_valid) else begin
                        $display("pass-through result not valid one cycle after accept");
                        errors++;
                    end
            end
        end

        t = 0;
        while ((exp_q.size() != 0 || !in_ready) && t < tmo) begin
            @(negedge clock);
            t++;
        end
        if (exp_q.size() != 0 || !in_ready) begin
            $display("timeout waiting for outstanding writebacks");
            timeouts++;
        end
        if (err_q.size() != 0) begin
            $display("AXI responses left without a writeback");
            errors++;
        end
        $display("checked %0d writebacks, errors %0d, assertion failures %0d, timeouts %0d",
                 checked, errors, u_lsu_top.u_asserts.fail_count, timeouts);
        if (errors == 0 && u_lsu_top.u_asserts.fail_count == 0 && timeouts == 0
            && checked == nreq) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/lsu_asserts.sv ====
`default_nettype none

module lsu_asserts (
    input wire        clock,
    input wire        reset,
    input wire        in_ready,
    input wire        arvalid,
    input wire        arready,
    input wire        awvalid,
    input wire        awready,
    input wire        wvalid,
    input wire        wready,
    input wire        wb_valid,
    input wire        wb_ready,
    input wire [31:0] wb_data,
    input wire [4:0]  wb_rd,
    input wire        wb_reg_wen,
    input wire [31:0] wb_pc,
    input wire        wb_err
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;                         // read by the testbench at the end

    ar_hold: assert property (@(posedge clock) disable iff (reset)
        arvalid && !arready |=> arvalid)
        else begin
            $error("arvalid dropped before handshake");
            fail_count++;
        end
    aw_hold: assert property (@(posedge clock) disable iff (reset)
        awvalid && !awready |=> awvalid)
        else begin
            $error("awvalid dropped before handshake");
            fail_count++;
        end
    w_hold: assert property (@(posedge clock) disable iff (reset)
        wvalid && !wready |=> wvalid)
        else begin
            $error("wvalid dropped before handshake");
            fail_count++;
        end

    wb_stall: assert property (@(posedge clock) disable iff (reset)
        wb_valid && !wb_ready |=> wb_valid && $stable(wb_data) && $stable(wb_rd)
            && $stable(wb_reg_wen) && $stable(wb_pc) && $stable(wb_err))
        else begin
            $error("writeback changed while stalled");
            fail_count++;
        end

    one_in_flight: assert property (@(posedge clock) disable iff (reset)
        wb_valid |-> !in_ready)
        else begin
            $error("in_ready high while wb_valid is high");
            fail_count++;
        end

endmodule

bind lsu_top lsu_asserts u_asserts (
    .clock(clock), .reset(reset), .in_ready(in_ready),
    .arvalid(arvalid), .arready(arready), .awvalid(awvalid), .awready(awready),
    .wvalid(wvalid), .wready(wready), .wb_valid(wb_valid), .wb_ready(wb_ready),
    .wb_data(wb_data), .wb_rd(wb_rd), .wb_reg_wen(wb_reg_wen), .wb_pc(wb_pc),
    .wb_err(wb_err)
);

`default_nettype wire

// ==== hw/lsu_top.sv ====
`default_nettype none

module lsu_top import lsu_pkg::*; #(
    parameter int unsigned           id_width = 4,
    parameter logic [id_width-1:0] axi_id   = '0
) (
    input  logic                clock,
    input  logic                reset,
    input  logic                in_valid,
    output logic                in_ready,
    input  logic [xlen-1:0]     in_pc,
    input  logic                in_mem_ren,
    input  logic                in_mem_wen,
    input  logic                in_reg_wen,
    input  logic [4:0]          in_rd,
    input  logic [2:0]          in_funct3,
    input  logic [xlen-1:0]     in_addr,
    input  logic [xlen-1:0]     in_store_data,
    output logic                wb_valid,
    input  logic                wb_ready,
    output logic [xlen-1:0]     wb_data,
    output logic [4:0]          wb_rd,
    output logic                wb_reg_wen,
    output logic [xlen-1:0]     wb_pc,
    output logic                wb_err,
    output logic                arvalid,
    input  logic                arready,
    output logic [xlen-1:0]     araddr,
    output logic [id_width-1:0] arid,
    output logic [7:0]          arlen,
    output logic [2:0]          arsize,
    output logic [1:0]          arburst,
    input  logic                rvalid,
    output logic                rready,
    input  logic [xlen-1:0]     rdata,
    input  logic [1:0]          rresp,
    input  logic                rlast,
    input  logic [id_width-1:0] rid,
    output logic                awvalid,
    input  logic                awready,
    output logic [xlen-1:0]     awaddr,
    output logic [id_width-1:0] awid,
    output logic [7:0]          awlen,
    output logic [2:0]          awsize,
    output logic [1:0]          awburst,
    output logic                wvalid,
    input  logic                wready,
    output logic [xlen-1:0]     wdata,
    output logic [3:0]          wstrb,
    output logic                wlast,
    input  logic                bvalid,
    output logic                bready,
    input  logic [1:0]          bresp,
    input  logic [id_width-1:0] bid
);

    logic            accept;
    logic            retire;
    logic [xlen-1:0] req_addr;
    logic [2:0]      req_funct3;
    logic [xlen-1:0] req_store_data;
    logic [4:0]      req_rd;
    logic            req_reg_wen;
    logic [xlen-1:0] req_pc;
    logic            req_is_load;
    logic            req_is_store;
    logic            load_done;
    logic [xlen-1:0] load_data;
    logic            load_err;
    logic            store_done;
    logic            store_err;

    lsu_issue u_issue (
        .clock          (clock),
        .reset          (reset),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .in_pc          (in_pc),
        .in_mem_ren     (in_mem_ren),
        .in_mem_wen     (in_mem_wen),
        .in_reg_wen     (in_reg_wen),
        .in_rd          (in_rd),
        .in_funct3      (in_funct3),
        .in_addr        (in_addr),
        .in_store_data  (in_store_data),
        .accept         (accept),
        .req_addr       (req_addr),
        .req_funct3     (req_funct3),
        .req_store_data (req_store_data),
        .req_rd         (req_rd),
        .req_reg_wen    (req_reg_wen),
        .req_pc         (req_pc),
        .req_is_load    (req_is_load),
        .req_is_store   (req_is_store),
        .retire         (retire)
    );

    lsu_load_port #(
        .id_width (id_width),
        .axi_id   (axi_id)
    ) u_load_port (
        .clock       (clock),
        .reset       (reset),
        .accept      (accept),
        .req_is_load (req_is_load),
        .req_addr    (req_addr),
        .req_funct3  (req_funct3),
        .load_done   (load_done),
        .load_data   (load_data),
        .load_err    (load_err),
        .arvalid     (arvalid),
        .arready     (arready),
        .araddr      (araddr),
        .arid        (arid),
        .arlen       (arlen),
        .arsize      (arsize),
        .arburst     (arburst),
        .rvalid      (rvalid),
        .rready      (rready),
        .rdata       (rdata),
        .rresp       (rresp),
        .rlast       (rlast),
        .rid         (rid)
    );

    lsu_store_port #(
        .id_width (id_width),
        .axi_id   (axi_id)
    ) u_store_port (
        .clock          (clock),
        .reset          (reset),
        .accept         (accept),
        .req_is_store   (req_is_store),
        .req_addr       (req_addr),
        .req_funct3     (req_funct3),
        .req_store_data (req_store_data),
        .store_done     (store_done),
        .store_err      (store_err),
        .awvalid        (awvalid),
        .awready        (awready),
        .awaddr         (awaddr),
        .awid           (awid),
        .awlen          (awlen),
        .awsize         (awsize),
        .awburst        (awburst),
        .wvalid         (wvalid),
        .wready         (wready),
        .wdata          (wdata),
        .wstrb          (wstrb),
        .wlast          (wlast),
        .bvalid         (bvalid),
        .bready         (bready),
        .bresp          (bresp),
        .bid            (bid)
    );

    lsu_writeback u_writeback (
        .clock        (clock),
        .reset        (reset),
        .accept       (accept),
        .req_is_load  (req_is_load),
        .req_is_store (req_is_store),
        .req_rd       (req_rd),
        .req_reg_wen  (req_reg_wen),
        .req_pc       (req_pc),
        .in_addr      (in_addr),
        .in_rd        (in_rd),
        .in_reg_wen   (in_reg_wen),
        .in_pc        (in_pc),
        .load_done    (load_done),
        .load_data    (load_data),
        .load_err     (load_err),
        .store_done   (store_done),
        .store_err    (store_err),
        .wb_valid     (wb_valid),
        .wb_data      (wb_data),
        .wb_rd        (wb_rd),
        .wb_reg_wen   (wb_reg_wen),
        .wb_pc        (wb_pc),
        .wb_err       (wb_err),
        .wb_ready     (wb_ready),
        .retire       (retire)
    );

endmodule

`default_nettype wire

// ==== hw/lsu_writeback.sv ====
`default_nettype none

module lsu_writeback import lsu_pkg::*; (
    input  logic            clock,
    input  logic            reset,
    input  logic            accept,
    input  logic            req_is_load,
    input  logic            req_is_store,
    input  logic [4:0]      req_rd,
    input  logic            req_reg_wen,
    input  logic [xlen-1:0] req_pc,
    input  logic [xlen-1:0] in_addr,
    input  logic [4:0]      in_rd,
    input  logic            in_reg_wen,
    input  logic [xlen-1:0] in_pc,
    input  logic            load_done,
    input  logic [xlen-1:0] load_data,
    input  logic            load_err,
    input  logic            store_done,
    input  logic            store_err,
    output logic            wb_valid,
    output logic [xlen-1:0] wb_data,
    output logic [4:0]      wb_rd,
    output logic            wb_reg_wen,
    output logic [xlen-1:0] wb_pc,
    output logic            wb_err,
    input  logic            wb_ready,
    output logic            retire
);

    logic pass;

    assign pass   = accept && !req_is_load && !req_is_store;
    assign retire = wb_valid && wb_ready;

    always_ff @(posedge clock) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else if (pass || load_done || store_done) begin
            wb_valid <= 1'b1;
        end else if (retire) begin
            wb_valid <= 1'b0;
        end
    end

    // the three sources are never active in the same cycle
    always_ff @(posedge clock) begin
        if (pass) begin
            wb_data    <= in_addr;                      // alu result passes through
            wb_rd      <= in_rd;
            wb_reg_wen <= in_reg_wen;
            wb_pc      <= in_pc;
            wb_err     <= 1'b0;
        end else if (load_done || store_done) begin
            wb_data    <= load_done ? load_data : '0;
            wb_rd      <= req_rd;
            wb_reg_wen <= req_reg_wen;
            wb_pc      <= req_pc;
            wb_err     <= load_done ? load_err : store_err;
        end
    end

endmodule

`default_nettype wire

// ==== hw/lsu_store_port.sv ====
`default_nettype none

module lsu_store_port import lsu_pkg::*; #(
    parameter int unsigned           id_width = 4,
    parameter logic [id_width-1:0] axi_id   = '0
) (
    input  logic                clock,
    input  logic                reset,
    input  logic                accept,
    input  logic                req_is_store,
    input  logic [xlen-1:0]     req_addr,
    input  logic [2:0]          req_funct3,
    input  logic [xlen-1:0]     req_store_data,
    output logic                store_done,
    output logic                store_err,
    output logic                awvalid,
    input  logic                awready,
    output logic [xlen-1:0]     awaddr,
    output logic [id_width-1:0] awid,
    output logic [7:0]          awlen,
    output logic [2:0]          awsize,
    output logic [1:0]          awburst,
    output logic                wvalid,
    input  logic                wready,
    output logic [xlen-1:0]     wdata,
    output logic [3:0]          wstrb,
    output logic                wlast,
    input  logic                bvalid,
    output logic                bready,
    input  logic [1:0]          bresp,
    input  logic [id_width-1:0] bid
);

    logic start;

    assign start = accept && req_is_store;

    // aw and w complete independently, in any order
    always_ff @(posedge clock) begin
        if (reset) begin
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            bready  <= 1'b0;
        end else if (start) begin
            awvalid <= 1'b1;
            wvalid  <= 1'b1;
            bready  <= 1'b1;
        end else begin
            if (awvalid && awready) awvalid <= 1'b0;
            if (wvalid && wready) wvalid <= 1'b0;
            if (bvalid && bready) bready <= 1'b0;
        end
    end

    assign awaddr  = req_addr;
    assign awid    = axi_id;
    assign awlen   = 8'd0;
    assign awburst = axi_burst_incr;
    assign wlast   = 1'b1;                               // always one beat

    always_comb begin
        case (req_funct3)
            funct3_sb: awsize = axi_size_byte;
            funct3_sh: awsize = axi_size_half;
            default:   awsize = axi_size_word;
        endcase
    end

    assign wdata = req_store_data << {req_addr[1:0], 3'b000};

    always_comb begin
        case (req_funct3)
            funct3_sb: wstrb = 4'b0001 << req_addr[1:0];
            funct3_sh: wstrb = 4'b0011 << req_addr[1:0];
            funct3_sw: wstrb = 4'b1111;
            default:   wstrb = 4'b0000;
        endcase
    end

    assign store_done = bvalid && bready;
    assign store_err  = (bresp != axi_resp_okay) || (bid != axi_id);

endmodule

`default_nettype wire

// ==== hw/lsu_load_port.sv ====
`default_nettype none

module lsu_load_port import lsu_pkg::*; #(
    parameter int unsigned           id_width = 4,
    parameter logic [id_width-1:0] axi_id   = '0
) (
    input  logic                clock,
    input  logic                reset,
    input  logic                accept,
    input  logic                req_is_load,
    input  logic [xlen-1:0]     req_addr,
    input  logic [2:0]          req_funct3,
    output logic                load_done,
    output logic [xlen-1:0]     load_data,
    output logic                load_err,
    output logic                arvalid,
    input  logic                arready,
    output logic [xlen-1:0]     araddr,
    output logic [id_width-1:0] arid,
    output logic [7:0]          arlen,
    output logic [2:0]          arsize,
    output logic [1:0]          arburst,
    input  logic                rvalid,
    output logic                rready,
    input  logic [xlen-1:0]     rdata,
    input  logic [1:0]          rresp,
    input  logic                rlast,
    input  logic [id_width-1:0] rid
);

    logic [xlen-1:0] lane_data;

    always_ff @(posedge clock) begin
        if (reset) begin
            arvalid <= 1'b0;
        end else if (accept && req_is_load) begin
            arvalid <= 1'b1;
        end else if (arvalid && arready) begin
            arvalid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            rready <= 1'b0;
        end else if (accept && req_is_load) begin
            rready <= 1'b1;
        end else if (rvalid && rready) begin
            rready <= 1'b0;
        end
    end

    assign araddr  = req_addr;
    assign arid    = axi_id;
    assign arlen   = 8'd0;                              // single beat
    assign arburst = axi_burst_incr;

    always_comb begin
        case (req_funct3)
            funct3_lb, funct3_lbu: arsize = axi_size_byte;
            funct3_lh, funct3_lhu: arsize = axi_size_half;
            default:               arsize = axi_size_word;
        endcase
    end

    assign lane_data = rdata >> {req_addr[1:0], 3'b000};  // addressed lane to bit 0

    always_comb begin
        case (req_funct3)
            funct3_lb:  load_data = {{24{lane_data[7]}}, lane_data[7:0]};
            funct3_lh:  load_data = {{16{lane_data[15]}}, lane_data[15:0]};
            funct3_lbu: load_data = {24'd0, lane_data[7:0]};
            funct3_lhu: load_data = {16'd0, lane_data[15:0]};
            default:    load_data = rdata;
        endcase
    end

    assign load_done = rvalid && rready;
    // a foreign id or a missing last is treated like a bad response
    assign load_err  = (rresp != axi_resp_okay) || (rid != axi_id) || !rlast;

endmodule

`default_nettype wire

// ==== hw/lsu_issue.sv ====
`default_nettype none

module lsu_issue import lsu_pkg::*; (
    input  logic            clock,
    input  logic            reset,
    input  logic            in_valid,
    output logic            in_ready,
    input  logic [xlen-1:0] in_pc,
    input  logic            in_mem_ren,
    input  logic            in_mem_wen,
    input  logic            in_reg_wen,
    input  logic [4:0]      in_rd,
    input  logic [2:0]      in_funct3,
    input  logic [xlen-1:0] in_addr,
    input  logic [xlen-1:0] in_store_data,
    output logic            accept,
    output logic [xlen-1:0] req_addr,
    output logic [2:0]      req_funct3,
    output logic [xlen-1:0] req_store_data,
    output logic [4:0]      req_rd,
    output logic            req_reg_wen,
    output logic [xlen-1:0] req_pc,
    output logic            req_is_load,
    output logic            req_is_store,
    input  logic            retire
);

    logic busy;
    logic held_load;
    logic held_store;
    logic in_is_store;

    assign in_ready    = !busy;
    assign accept      = in_valid && in_ready;
    assign in_is_store = in_mem_wen && !in_mem_ren;    // load wins if both set

    always_ff @(posedge clock) begin
        if (reset) begin
            busy       <= 1'b0;
            held_load  <= 1'b0;
            held_store <= 1'b0;
        end else if (accept) begin
            busy       <= 1'b1;
            held_load  <= in_mem_ren;
            held_store <= in_is_store;
        end else if (retire) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            req_addr       <= in_addr;
            req_funct3     <= in_funct3;
            req_store_data <= in_store_data;
            req_rd         <= in_rd;
            req_reg_wen    <= in_reg_wen;
            req_pc         <= in_pc;
        end
    end

    // the ports see the incoming kind on the accept cycle, the held kind after
    assign req_is_load  = busy ? held_load : in_mem_ren;
    assign req_is_store = busy ? held_store : in_is_store;

endmodule

`default_nettype wire

// ==== hw/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

    localparam int xlen = 32;                      // data and address width

    // load width codes
    localparam logic [2:0] funct3_lb  = 3'b000;
    localparam logic [2:0] funct3_lh  = 3'b001;
    localparam logic [2:0] funct3_lw  = 3'b010;
    localparam logic [2:0] funct3_lbu = 3'b100;
    localparam logic [2:0] funct3_lhu = 3'b101;

    // store width codes
    localparam logic [2:0] funct3_sb = 3'b000;
    localparam logic [2:0] funct3_sh = 3'b001;
    localparam logic [2:0] funct3_sw = 3'b010;

    // AXI beat size, bytes = 2**size
    localparam logic [2:0] axi_size_byte = 3'b000;
    localparam logic [2:0] axi_size_half = 3'b001;
    localparam logic [2:0] axi_size_word = 3'b010;

    localparam logic [1:0] axi_burst_incr = 2'b01;

    localparam logic [1:0] axi_resp_okay = 2'b00;  // anything else is an error

endpackage

`default_nettype wire
